/* common/scaler_pkg.sv */
package scaler_pkg;

    // sample and arithmetic widths
    localparam int SAMPLE_W = 16;
    localparam int GAIN_W = 16;
    // shift range is 0 to 15
    localparam int SHIFT_W = 4;
    // full product of sample and gain, no loss
    localparam int PROD_W = SAMPLE_W + GAIN_W;

    // clamp limits for a signed sample
    localparam logic signed [SAMPLE_W-1:0] SAT_MAX = {1'b0, {(SAMPLE_W-1){1'b1}}};
    localparam logic signed [SAMPLE_W-1:0] SAT_MIN = {1'b1, {(SAMPLE_W-1){1'b0}}};

    // configuration port address width
    localparam int CFG_ADDR_W = 2;

    // output reduction mode
    typedef enum logic {
        MODE_WRAP = 1'b0,   // keep the low sample bits
        MODE_SAT  = 1'b1    // clamp to SAT_MIN..SAT_MAX
    } mode_e;

    // configuration register map
    typedef enum logic [CFG_ADDR_W-1:0] {
        CFG_MODE   = 2'd0,
        CFG_GAIN   = 2'd1,
        CFG_SHIFT  = 2'd2,
        CFG_OFFSET = 2'd3
    } cfg_addr_e;

    // beat on the input and output streams
    typedef struct packed {
        logic signed [SAMPLE_W-1:0] data;
        logic                       last;
    } sample_beat_t;

    // beat between the scale and offset stages
    typedef struct packed {
        logic signed [PROD_W-1:0] data;
        logic                     last;
    } scaled_beat_t;

    // settings that steer the datapath
    typedef struct packed {
        mode_e                      mode;
        logic signed [GAIN_W-1:0]   gain;
        logic [SHIFT_W-1:0]         shift;
        logic signed [SAMPLE_W-1:0] offset;
    } cfg_t;

endpackage

/* logic/pipe_regs.sv */
`timescale 1ns/10ps

module pipe_regs #(
    parameter int DATA_WIDTH = 32
) (
    input  logic                  clk,
    input  logic                  rst_n,

    // upstream side
    input  logic                  i_valid,
    output logic                  i_ready,
    input  logic [DATA_WIDTH-1:0] i_data,

    // downstream side
    output logic                  o_valid,
    input  logic                  o_ready,
    output logic [DATA_WIDTH-1:0] o_data
);

    // occupancy of the two registers
    // the skid buffer never holds data while the output register is empty
    typedef enum logic [1:0] {
        EMPTY = 2'd0,   // nothing held
        BUSY  = 2'd1,   // output register holds a beat
        FULL  = 2'd2    // output register and skid buffer both hold a beat
    } pipe_state_e;

    pipe_state_e state;
    pipe_state_e state_next;

    logic [DATA_WIDTH-1:0] skid_data;
    logic [DATA_WIDTH-1:0] out_next;

    logic insert;
    logic remove;
    logic load;
    logic flow;
    logic fill;
    logic flush;
    logic unload;

    // handshakes on each side
    assign insert = i_valid && i_ready;
    assign remove = o_valid && o_ready;

    // empty pipe takes a new beat into the output register
    assign load   = (state == EMPTY) && insert && !remove;
    // new beat replaces the one leaving
    assign flow   = (state == BUSY) && insert && remove;
    // output stalled, new beat parks in the skid buffer
    assign fill   = (state == BUSY) && insert && !remove;
    // skid beat moves up as the output beat leaves
    assign flush  = (state == FULL) && !insert && remove;
    // last beat leaves, pipe goes empty
    assign unload = (state == BUSY) && !insert && remove;

    // at most one transition fires per cycle
    always_comb begin
        state_next = state;
        if (load || flow || flush) begin
            state_next = BUSY;
        end
        if (fill) begin
            state_next = FULL;
        end
        if (unload) begin
            state_next = EMPTY;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= EMPTY;
        end else begin
            state <= state_next;
        end
    end

    // both control outputs come straight from flops
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            i_ready <= 1'b1;
            o_valid <= 1'b0;
        end else begin
            i_ready <= (state_next != FULL);
            o_valid <= (state_next != EMPTY);
        end
    end

    // flush takes the parked beat, otherwise the incoming one
    assign out_next = flush ? skid_data : i_data;

    // skid buffer, written only on fill
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            skid_data <= '0;
        end else if (fill) begin
            skid_data <= i_data;
        end
    end

    // output register
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            o_data <= '0;
        end else if (load || flow || flush) begin
            o_data <= out_next;
        end
    end

endmodule

/* logic/scaler_cfg.sv */
`timescale 1ns/10ps

module scaler_cfg (
    input  logic                            clk,
    input  logic                            rst_n,

    // write strobe port
    input  logic                            i_cfg_we,
    input  scaler_pkg::cfg_addr_e           i_cfg_addr,
    input  logic [scaler_pkg::SAMPLE_W-1:0] i_cfg_wdata,

    // settings to the datapath
    output scaler_pkg::cfg_t                o_cfg
);

    // one field per address, held until rewritten
    // reset leaves gain 0, shift 0, offset 0 and wrap mode
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            o_cfg <= '0;
        end else if (i_cfg_we) begin
            case (i_cfg_addr)
                scaler_pkg::CFG_MODE: begin
                    // only bit 0 selects the mode
                    o_cfg.mode <= scaler_pkg::mode_e'(i_cfg_wdata[0]);
                end
                scaler_pkg::CFG_GAIN: begin
                    o_cfg.gain <= i_cfg_wdata;
                end
                scaler_pkg::CFG_SHIFT: begin
                    // upper bits dropped, range 0 to 15
                    o_cfg.shift <= i_cfg_wdata[scaler_pkg::SHIFT_W-1:0];
                end
                scaler_pkg::CFG_OFFSET: begin
                    o_cfg.offset <= i_cfg_wdata;
                end
            endcase
        end
    end

endmodule

/* logic/scale_stage.sv */
`timescale 1ns/10ps

module scale_stage (
    input  logic                                  clk,
    input  logic                                  rst_n,

    // upstream stream
    input  logic                                  i_valid,
    output logic                                  o_ready,
    input  scaler_pkg::sample_beat_t              i_beat,

    // settings
    input  logic signed [scaler_pkg::GAIN_W-1:0]  i_gain,
    input  logic [scaler_pkg::SHIFT_W-1:0]        i_shift,

    // downstream stream
    output logic                                  o_valid,
    input  logic                                  i_ready_dn,
    output scaler_pkg::scaled_beat_t              o_beat
);

    logic signed [scaler_pkg::PROD_W-1:0] product;
    logic signed [scaler_pkg::PROD_W-1:0] shifted;
    scaler_pkg::scaled_beat_t              scaled;

    // both operands signed, so the 32-bit product keeps its sign
    assign product = i_beat.data * i_gain;

    // arithmetic shift rounds toward minus infinity
    assign shifted = product >>> i_shift;

    assign scaled.data = shifted;
    assign scaled.last = i_beat.last;

    // one cycle register slice behind the arithmetic
    pipe_regs #(
        .DATA_WIDTH ($bits(scaler_pkg::scaled_beat_t))
    ) u_regs (
        .clk     (clk),
        .rst_n   (rst_n),
        .i_valid (i_valid),
        .i_ready (o_ready),
        .i_data  (scaled),
        .o_valid (o_valid),
        .o_ready (i_ready_dn),
        .o_data  (o_beat)
    );

endmodule

/* logic/offset_sat_stage.sv */
`timescale 1ns/10ps

module offset_sat_stage (
    input  logic                                   clk,
    input  logic                                   rst_n,

    // upstream stream
    input  logic                                   i_valid,
    output logic                                   o_ready,
    input  scaler_pkg::scaled_beat_t               i_beat,

    // settings
    input  logic signed [scaler_pkg::SAMPLE_W-1:0] i_offset,
    input  scaler_pkg::mode_e                      i_mode,

    // downstream stream
    output logic                                   o_valid,
    input  logic                                   i_ready_dn,
    output scaler_pkg::sample_beat_t               o_beat
);

    // one guard bit over the product width
    logic signed [scaler_pkg::PROD_W:0] sum;
    scaler_pkg::sample_beat_t           reduced;

    // signed context, both operands sign-extended to the sum width
    assign sum = i_beat.data + i_offset;

    // reduce to sample width
    always_comb begin
        reduced.last = i_beat.last;
        reduced.data = sum[scaler_pkg::SAMPLE_W-1:0];
        if (i_mode == scaler_pkg::MODE_SAT) begin
            if (sum > scaler_pkg::SAT_MAX) begin
                reduced.data = scaler_pkg::SAT_MAX;
            end else if (sum < scaler_pkg::SAT_MIN) begin
                reduced.data = scaler_pkg::SAT_MIN;
            end
        end
    end

    // output register slice, drives the stream out of the scaler
    pipe_regs #(
        .DATA_WIDTH ($bits(scaler_pkg::sample_beat_t))
    ) u_regs (
        .clk     (clk),
        .rst_n   (rst_n),
        .i_valid (i_valid),
        .i_ready (o_ready),
        .i_data  (reduced),
        .o_valid (o_valid),
        .o_ready (i_ready_dn),
        .o_data  (o_beat)
    );

endmodule

/* logic/stream_scaler.sv */
`timescale 1ns/10ps

module stream_scaler (
    input  logic                            clk,
    input  logic                            rst_n,

    // sample input stream
    input  logic                            i_s_valid,
    output logic                            o_s_ready,
    input  scaler_pkg::sample_beat_t        i_s_beat,

    // sample output stream
    output logic                            o_m_valid,
    input  logic                            i_m_ready,
    output scaler_pkg::sample_beat_t        o_m_beat,

    // configuration writes, only while drained
    input  logic                            i_cfg_we,
    input  scaler_pkg::cfg_addr_e           i_cfg_addr,
    input  logic [scaler_pkg::SAMPLE_W-1:0] i_cfg_wdata
);

    // input slice to scale stage
    logic                     in_valid;
    logic                     in_ready;
    scaler_pkg::sample_beat_t in_beat;

    // scale stage to offset stage
    logic                     scl_valid;
    logic                     scl_ready;
    scaler_pkg::scaled_beat_t scl_beat;

    scaler_pkg::cfg_t         cfg;

    // registers the input so the port sees flop-driven ready
    pipe_regs #(
        .DATA_WIDTH ($bits(scaler_pkg::sample_beat_t))
    ) u_in_regs (
        .clk     (clk),
        .rst_n   (rst_n),
        .i_valid (i_s_valid),
        .i_ready (o_s_ready),
        .i_data  (i_s_beat),
        .o_valid (in_valid),
        .o_ready (in_ready),
        .o_data  (in_beat)
    );

    scaler_cfg u_cfg (
        .clk         (clk),
        .rst_n       (rst_n),
        .i_cfg_we    (i_cfg_we),
        .i_cfg_addr  (i_cfg_addr),
        .i_cfg_wdata (i_cfg_wdata),
        .o_cfg       (cfg)
    );

    // gain and shift
    scale_stage u_scale (
        .clk        (clk),
        .rst_n      (rst_n),
        .i_valid    (in_valid),
        .o_ready    (in_ready),
        .i_beat     (in_beat),
        .i_gain     (cfg.gain),
        .i_shift    (cfg.shift),
        .o_valid    (scl_valid),
        .i_ready_dn (scl_ready),
        .o_beat     (scl_beat)
    );

    // offset and reduction
    offset_sat_stage u_offset_sat (
        .clk        (clk),
        .rst_n      (rst_n),
        .i_valid    (scl_valid),
        .o_ready    (scl_ready),
        .i_beat     (scl_beat),
        .i_offset   (cfg.offset),
        .i_mode     (cfg.mode),
        .o_valid    (o_m_valid),
        .i_ready_dn (i_m_ready),
        .o_beat     (o_m_beat)
    );

endmodule

/* tests/tb_stream_scaler.sv */
`timescale 1ns/10ps

module tb_stream_scaler;

    localparam int N_BURST = 16;
    localparam int N_RAND = 48;
    localparam int N_HOLD = 10;
    localparam int TOTAL_BEATS = N_BURST + 3 * N_RAND + N_HOLD;
    // reset, config writes, drains and the hold-off stall
    localparam int TIMEOUT_CYCLES = 4 * TOTAL_BEATS + 100 + 10;

    logic                            clk;
    logic                            rst_n;
    logic                            i_s_valid;
    logic                            o_s_ready;
    scaler_pkg::sample_beat_t        i_s_beat;
    logic                            o_m_valid;
    logic                            i_m_ready;
    scaler_pkg::sample_beat_t        o_m_beat;
    logic                            i_cfg_we;
    scaler_pkg::cfg_addr_e           i_cfg_addr;
    logic [scaler_pkg::SAMPLE_W-1:0] i_cfg_wdata;

    logic [31:0]              lfsr = 32'h6c6fa797;
    int                       cycle = 0;
    bit                       random_ready = 1'b0;
    bit                       check_latency = 1'b0;
    // what the DUT registers should hold
    scaler_pkg::cfg_t         cfg_model = '0;
    scaler_pkg::sample_beat_t exp_q[$];
    int                       accept_q[$];
    scaler_pkg::sample_beat_t stim[N_RAND];

    stream_scaler i_stream_scaler (
        .clk         (clk),
        .rst_n       (rst_n),
        .i_s_valid   (i_s_valid),
        .o_s_ready   (o_s_ready),
        .i_s_beat    (i_s_beat),
        .o_m_valid   (o_m_valid),
        .i_m_ready   (i_m_ready),
        .o_m_beat    (o_m_beat),
        .i_cfg_we    (i_cfg_we),
        .i_cfg_addr  (i_cfg_addr),
        .i_cfg_wdata (i_cfg_wdata)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    task automatic stop_run();
        $display("Test failures found");
        $fatal(1, "run stopped at first failure");
    endtask

    initial begin
        wait (cycle >= TIMEOUT_CYCLES);
        $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
        stop_run();
    end

    // fibonacci lfsr, taps 32 22 2 1, one step per bit
    function automatic logic [15:0] rand_bits(input int n);
        logic [15:0] r;
        r = '0;
        for (int k = 0; k < n; k++) begin
            lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
            r = {r[14:0], lfsr[0]};
        end
        return r;
    endfunction

    // exact product, floor shift, offset, then 16-bit reduction
    function automatic scaler_pkg::sample_beat_t expected_beat(
        input scaler_pkg::sample_beat_t in,
        input scaler_pkg::cfg_t         c
    );
        longint                   value;
        scaler_pkg::sample_beat_t res;
        value = longint'($signed(in.data)) * longint'($signed(c.gain));
        value = value >>> c.shift;
        value = value + longint'($signed(c.offset));
        res.last = in.last;
        if (c.mode == scaler_pkg::MODE_SAT && value > 32767) begin
            res.data = 16'h7fff;
        end else if (c.mode == scaler_pkg::MODE_SAT && value < -32768) begin
            res.data = 16'h8000;
        end else begin
            res.data = value[15:0];
        end
        return res;
    endfunction

    task automatic check_beat(input string name, input scaler_pkg::sample_beat_t got,
                              input scaler_pkg::sample_beat_t exp);
        if (got !== exp) begin
            $display("** Error at %0t: %s got data %0d last %b, expected data %0d last %b",
                     $time, name, got.data, got.last, exp.data, exp.last);
            stop_run();
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("** Error at %0t: %s got %b, expected %b", $time, name, got, exp);
            stop_run();
        end
    endtask

    task automatic check_cycles(input string name, input int got, input int exp);
        if (got != exp) begin
            $display("** Error at %0t: %s got %0d, expected %0d", $time, name, got, exp);
            stop_run();
        end
    endtask

    // every driver wait lands on a falling edge
    task automatic next_cycle();
        @(negedge clk);
        if (random_ready) begin
            i_m_ready = (rand_bits(1) != 0);
        end
    endtask

    task automatic send_beat(input scaler_pkg::sample_beat_t b);
        i_s_valid = 1'b1;
        i_s_beat = b;
        while (!o_s_ready) begin
            next_cycle();
        end
        // transfer happens on the coming rising edge
        exp_q.push_back(expected_beat(b, cfg_model));
        accept_q.push_back(cycle);
        next_cycle();
    endtask

    task automatic idle(input int n);
        i_s_valid = 1'b0;
        repeat (n) next_cycle();
    endtask

    task automatic drain();
        random_ready = 1'b0;
        i_m_ready = 1'b1;
        i_s_valid = 1'b0;
        while (exp_q.size() != 0) begin
            next_cycle();
        end
        next_cycle();
    endtask

    task automatic write_cfg(input scaler_pkg::cfg_addr_e addr, input logic [15:0] data);
        i_cfg_we = 1'b1;
        i_cfg_addr = addr;
        i_cfg_wdata = data;
        next_cycle();
        i_cfg_we = 1'b0;
        // mode keeps bit 0, shift keeps the low 4 bits
        case (addr)
            scaler_pkg::CFG_MODE: cfg_model.mode = scaler_pkg::mode_e'(data[0]);
            scaler_pkg::CFG_GAIN: cfg_model.gain = data;
            scaler_pkg::CFG_SHIFT: cfg_model.shift = data[3:0];
            default: cfg_model.offset = data;
        endcase
    endtask

    // scoreboard, samples 1 ns after the falling edge
    initial begin
        scaler_pkg::sample_beat_t exp;
        int                       accepted;
        forever begin
            @(negedge clk);
            #1;
            if (rst_n && o_m_valid && i_m_ready) begin
                if (exp_q.size() == 0) begin
                    $display("output beat at %0t with no beat expected", $time);
                    stop_run();
                end else begin
                    exp = exp_q.pop_front();
                    accepted = accept_q.pop_front();
                    check_beat("o_m_beat", o_m_beat, exp);
                    if (check_latency) begin
                        check_cycles("latency", cycle - accepted, 3);
                    end
                end
            end
        end
    end

    initial begin
        scaler_pkg::sample_beat_t b;
        int                       n;
        logic [15:0]              gain;
        rst_n = 1'b0;
        i_s_valid = 1'b0;
        i_s_beat = '0;
        i_m_ready = 1'b1;
        i_cfg_we = 1'b0;
        i_cfg_addr = scaler_pkg::CFG_MODE;
        i_cfg_wdata = '0;
        repeat (10) @(negedge clk);
        check_bit("o_m_valid", o_m_valid, 1'b0);
        check_bit("o_s_ready", o_s_ready, 1'b1);
        rst_n = 1'b1;
        next_cycle();

        // unity gain in saturate mode passes samples through
        write_cfg(scaler_pkg::CFG_GAIN, 16'd1);
        write_cfg(scaler_pkg::CFG_MODE, 16'd1);
        check_latency = 1'b1;
        for (int k = 0; k < N_BURST; k++) begin
            b.data = rand_bits(16);
            b.last = (k == N_BURST - 1);
            check_bit("o_s_ready", o_s_ready, 1'b1);
            send_beat(b);
        end
        drain();
        check_latency = 1'b0;

        // bit 14 opposite the sign bit keeps the gain magnitude at 2^14 or more
        gain = rand_bits(16);
        gain[14] = ~gain[15];
        // shift kept below 8 so large gains hit the clamp, upper bits test truncation
        write_cfg(scaler_pkg::CFG_GAIN, gain);
        write_cfg(scaler_pkg::CFG_SHIFT, rand_bits(16) & 16'hfff7);
        write_cfg(scaler_pkg::CFG_OFFSET, rand_bits(16));
        for (int k = 0; k < N_RAND; k++) begin
            stim[k].data = rand_bits(16);
            stim[k].last = (rand_bits(1) != 0);
            send_beat(stim[k]);
        end
        drain();

        // same samples, wrap mode
        write_cfg(scaler_pkg::CFG_MODE, 16'd0);
        for (int k = 0; k < N_RAND; k++) begin
            send_beat(stim[k]);
        end
        drain();

        // random back-pressure and input gaps
        write_cfg(scaler_pkg::CFG_MODE, 16'd1);
        random_ready = 1'b1;
        for (int k = 0; k < N_RAND; k++) begin
            if (rand_bits(2) == 0) begin
                idle(1 + rand_bits(2));
            end
            b.data = rand_bits(16);
            b.last = (rand_bits(1) != 0);
            send_beat(b);
        end
        drain();

        // output stalled until the input side fills up
        i_m_ready = 1'b0;
        n = 0;
        while (o_s_ready && n < N_HOLD) begin
            b.data = rand_bits(16);
            b.last = (rand_bits(1) != 0);
            send_beat(b);
            n++;
        end
        idle(4);
        check_bit("o_s_ready", o_s_ready, 1'b0);
        check_bit("o_m_valid", o_m_valid, 1'b1);
        drain();

        if (exp_q.size() != 0) begin
            $display("%0d expected beats never left the DUT", exp_q.size());
            stop_run();
        end else begin
            $display("All tests passed!");
            $finish;
        end
    end

endmodule

/* tb.f */
common/scaler_pkg.sv
logic/pipe_regs.sv
logic/scaler_cfg.sv
logic/scale_stage.sv
logic/offset_sat_stage.sv
logic/stream_scaler.sv
tests/tb_stream_scaler.sv
